// ==== Bender.yml ====
package:
  name: sprite_overlay

dependencies: {}

sources:
  # Packages first, then the blocks, then the top level
  - files:
      - rtl/overlay_pkg.sv
      - rtl/regmap_pkg.sv
      - rtl/overlay_regs.sv
      - rtl/sprite_bitmap.sv
      - rtl/sprite_window.sv
      - rtl/sprite_overlay.sv

  # Testbench and bound assertions, top module tb_sprite_overlay
  - target: test
    files:
      - tests/sprite_overlay_assertions.sv
      - tests/tb_sprite_overlay.sv

// ==== rtl/overlay_pkg.sv ====
package overlay_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pixel word: opaque flag on top, then RGB 3-3-2
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int PIXEL_W    = 9;
	localparam int OPAQUE_BIT = 8;

	localparam int RED_W   = 3; // Bits 7:5
	localparam int GREEN_W = 3; // Bits 4:2
	localparam int BLUE_W  = 2; // Bits 1:0

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Beam geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int COORD_W = 10; // Beam counters and sprite position

	localparam int DEF_SPRITE_W = 150;
	localparam int DEF_SPRITE_H = 25;

endpackage

// ==== rtl/overlay_regs.sv ====
`timescale 1ns/100ps

module overlay_regs
	import overlay_pkg::*, regmap_pkg::*;
#(
	parameter int sprite_w     = 8,
	parameter int sprite_h     = 8,
	parameter int bitmap_depth = 64,
	parameter int bitmap_adr_w = 6
) (
	input  logic                    clock,
	input  logic                    arst_n,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [WB_ADR_W-1:0]     wb_adr,
	input  logic [WB_DAT_W-1:0]     wb_dat_w,
	output logic [WB_DAT_W-1:0]     wb_dat_r,
	output logic                    wb_ack,
	output logic                    enable,
	output logic [COORD_W-1:0]      pos_x,
	output logic [COORD_W-1:0]      pos_y,
	output logic                    bitmap_we,
	output logic [bitmap_adr_w-1:0] bitmap_wadr,
	output logic [PIXEL_W-1:0]      bitmap_wdata
);

	logic                req;
	logic [WB_ADR_W-1:0] bmp_index;
	logic                bmp_hit;

	// The bitmap has to fit in the space above BITMAP_BASE
	if (bitmap_depth != sprite_w * sprite_h || bitmap_depth > 2**WB_ADR_W - BITMAP_BASE)
	begin : g_map_check
		$error("Sprite bitmap does not fit the register map");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign req       = wb_cyc & wb_stb & ~wb_ack; // Gap of one cycle between accesses
	assign bmp_index = wb_adr - BITMAP_BASE;
	assign bmp_hit   = (wb_adr >= BITMAP_BASE) && (bmp_index < bitmap_depth);

	// Memory samples these on the edge that raises ack
	assign bitmap_we    = req & wb_we & bmp_hit;
	assign bitmap_wadr  = bmp_index[bitmap_adr_w-1:0];
	assign bitmap_wdata = wb_dat_w[PIXEL_W-1:0];

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= req;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control and position registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			enable <= 1'b0;
			pos_x  <= '0;
			pos_y  <= '0;
		end
		else if (req && wb_we)
		begin
			case (wb_adr)
				REG_CTRL:  enable <= wb_dat_w[0];
				REG_POS_X: pos_x  <= wb_dat_w[COORD_W-1:0];
				REG_POS_Y: pos_y  <= wb_dat_w[COORD_W-1:0];
				default:   ; // Bitmap and unmapped words leave the registers alone
			endcase
		end
	end

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			wb_dat_r <= '0;
		else if (req && !wb_we)
		begin
			case (wb_adr)
				REG_CTRL:  wb_dat_r <= WB_DAT_W'(enable);
				REG_POS_X: wb_dat_r <= WB_DAT_W'(pos_x);
				REG_POS_Y: wb_dat_r <= WB_DAT_W'(pos_y);
				default:   wb_dat_r <= '0; // Bitmap is write only
			endcase
		end
	end

endmodule

// ==== rtl/regmap_pkg.sv ====
package regmap_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wishbone port geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int WB_ADR_W = 13; // Word address
	localparam int WB_DAT_W = 16;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [WB_ADR_W-1:0] REG_CTRL  = WB_ADR_W'(0); // Bit 0 is enable
	localparam logic [WB_ADR_W-1:0] REG_POS_X = WB_ADR_W'(1);
	localparam logic [WB_ADR_W-1:0] REG_POS_Y = WB_ADR_W'(2);

	// Pixel index is row * width + column, data bits 8:0
	localparam logic [WB_ADR_W-1:0] BITMAP_BASE = WB_ADR_W'(4096);

endpackage

// ==== rtl/sprite_bitmap.sv ====
`timescale 1ns/100ps

module sprite_bitmap
	import overlay_pkg::*;
#(
	parameter int depth = 64,
	parameter int adr_w = 6
) (
	input  logic               clock,
	input  logic               we,
	input  logic [adr_w-1:0]   wadr,
	input  logic [PIXEL_W-1:0] wdata,
	input  logic [adr_w-1:0]   rd_adr,
	output logic [PIXEL_W-1:0] rd_data
);

	logic [PIXEL_W-1:0] mem [depth];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus write port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock)
	begin
		if (we)
			mem[wadr] <= wdata;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pixel read port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock)
	begin
		rd_data <= mem[rd_adr]; // Old word when written on the same edge
	end

endmodule

// ==== rtl/sprite_overlay.sv ====
`timescale 1ns/100ps

module sprite_overlay
	import overlay_pkg::*, regmap_pkg::*;
#(
	parameter int sprite_w = DEF_SPRITE_W,
	parameter int sprite_h = DEF_SPRITE_H
) (
	input  logic                clock,
	input  logic                arst_n,
	input  logic [COORD_W-1:0]  hcount,
	input  logic [COORD_W-1:0]  vcount,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  logic [WB_ADR_W-1:0] wb_adr,
	input  logic [WB_DAT_W-1:0] wb_dat_w,
	output logic [WB_DAT_W-1:0] wb_dat_r,
	output logic                wb_ack,
	output logic [RED_W-1:0]    red,
	output logic [GREEN_W-1:0]  green,
	output logic [BLUE_W-1:0]   blue,
	output logic                data
);

	localparam int bitmap_depth = sprite_w * sprite_h;
	localparam int bitmap_adr_w = $clog2(bitmap_depth);

	localparam int green_lsb = BLUE_W;
	localparam int red_lsb   = BLUE_W + GREEN_W;

	logic                    enable;
	logic [COORD_W-1:0]      pos_x;
	logic [COORD_W-1:0]      pos_y;
	logic                    bitmap_we;
	logic [bitmap_adr_w-1:0] bitmap_wadr;
	logic [PIXEL_W-1:0]      bitmap_wdata;
	logic                    in_window;
	logic [bitmap_adr_w-1:0] rd_adr;
	logic [PIXEL_W-1:0]      pixel;
	logic                    in_window_q;
	logic                    enable_q;

	overlay_regs #(
		.sprite_w     (sprite_w),
		.sprite_h     (sprite_h),
		.bitmap_depth (bitmap_depth),
		.bitmap_adr_w (bitmap_adr_w)
	) u_regs (
		.clock        (clock),
		.arst_n       (arst_n),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.enable       (enable),
		.pos_x        (pos_x),
		.pos_y        (pos_y),
		.bitmap_we    (bitmap_we),
		.bitmap_wadr  (bitmap_wadr),
		.bitmap_wdata (bitmap_wdata)
	);

	sprite_window #(
		.sprite_w     (sprite_w),
		.sprite_h     (sprite_h),
		.bitmap_adr_w (bitmap_adr_w)
	) u_window (
		.clock     (clock),
		.arst_n    (arst_n),
		.hcount    (hcount),
		.vcount    (vcount),
		.pos_x     (pos_x),
		.pos_y     (pos_y),
		.in_window (in_window),
		.rd_adr    (rd_adr)
	);

	sprite_bitmap #(
		.depth (bitmap_depth),
		.adr_w (bitmap_adr_w)
	) u_bitmap (
		.clock   (clock),
		.we      (bitmap_we),
		.wadr    (bitmap_wadr),
		.wdata   (bitmap_wdata),
		.rd_adr  (rd_adr),
		.rd_data (pixel)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage two, aligned with the bitmap word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			in_window_q <= 1'b0;
			enable_q    <= 1'b0;
		end
		else
		begin
			in_window_q <= in_window;
			enable_q    <= enable;
		end
	end

	assign data  = in_window_q & enable_q & pixel[OPAQUE_BIT];
	assign red   = data ? pixel[red_lsb +: RED_W] : '0; // Transparent pixels show black
	assign green = data ? pixel[green_lsb +: GREEN_W] : '0;
	assign blue  = data ? pixel[0 +: BLUE_W] : '0;

endmodule

// ==== rtl/sprite_window.sv ====
`timescale 1ns/100ps

module sprite_window
	import overlay_pkg::*;
#(
	parameter int sprite_w     = 8,
	parameter int sprite_h     = 8,
	parameter int bitmap_adr_w = 6
) (
	input  logic                    clock,
	input  logic                    arst_n,
	input  logic [COORD_W-1:0]      hcount,
	input  logic [COORD_W-1:0]      vcount,
	input  logic [COORD_W-1:0]      pos_x,
	input  logic [COORD_W-1:0]      pos_y,
	output logic                    in_window,
	output logic [bitmap_adr_w-1:0] rd_adr
);

	logic [COORD_W-1:0]      col;
	logic [COORD_W-1:0]      row;
	logic                    hit_x;
	logic                    hit_y;
	logic [bitmap_adr_w-1:0] adr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Hit test
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign col = hcount - pos_x; // Wrapped value is masked by the lower bound test
	assign row = vcount - pos_y;

	assign hit_x = (hcount >= pos_x) && (col < sprite_w);
	assign hit_y = (vcount >= pos_y) && (row < sprite_h);

	// Row major, one word per pixel
	assign adr = (hit_x && hit_y) ? bitmap_adr_w'(row * sprite_w + col) : '0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage one
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			in_window <= 1'b0;
			rd_adr    <= '0;
		end
		else
		begin
			in_window <= hit_x & hit_y;
			rd_adr    <= adr;
		end
	end

endmodule

// ==== src.f ====
rtl/overlay_pkg.sv
rtl/regmap_pkg.sv
rtl/overlay_regs.sv
rtl/sprite_bitmap.sv
rtl/sprite_window.sv
rtl/sprite_overlay.sv
tests/sprite_overlay_assertions.sv
tests/tb_sprite_overlay.sv

// ==== tests/sprite_overlay_assertions.sv ====
`timescale 1ns/100ps

module sprite_overlay_assertions
	import overlay_pkg::*;
(
	input logic               clock,
	input logic               arst_n,
	input logic               wb_cyc,
	input logic               wb_stb,
	input logic               wb_ack,
	input logic [RED_W-1:0]   red,
	input logic [GREEN_W-1:0] green,
	input logic [BLUE_W-1:0]  blue,
	input logic               data
);

	int failures = 0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wishbone classic handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	ack_in_cycle: assert property (@(posedge clock) disable iff (!arst_n)
		wb_ack |-> wb_cyc && wb_stb)
	else
	begin
		$error("wb_ack high outside a bus cycle");
		failures++;
	end

	ack_single: assert property (@(posedge clock) disable iff (!arst_n) wb_ack |=> !wb_ack)
	else
	begin
		$error("wb_ack high for two cycles in a row");
		failures++;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pixel outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	black_when_idle: assert property (@(posedge clock) disable iff (!arst_n)
		!data |-> red == '0 && green == '0 && blue == '0)
	else
	begin
		$error("Colour not zero while data is low");
		failures++;
	end

	quiet_in_reset: assert property (@(posedge clock) !arst_n |-> !wb_ack && !data)
	else
	begin
		$error("wb_ack or data high during reset");
		failures++;
	end

endmodule

bind sprite_overlay sprite_overlay_assertions u_assertions (.*);

// ==== tests/tb_sprite_overlay.sv ====
`timescale 1ns/100ps

module tb_sprite_overlay
	import overlay_pkg::*, regmap_pkg::*;
();

	localparam int sprite_w = 24;
	localparam int sprite_h = 8;
	localparam int depth    = sprite_w * sprite_h;
	localparam int margin   = 4; // Pixels swept around the window on every side
	localparam int screen   = 2**COORD_W;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Run length: six sweeps and three cycles per bus access
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int sweep_cycles = (sprite_w + 2 * margin) * (sprite_h + 2 * margin) + 4;
	localparam int accesses     = 3 + 8 * 6 + (depth + 3) + 3 + 4 + 9;
	localparam int cycle_limit  = (4 + 6 * sweep_cycles + 3 * accesses) * 5 / 4;

	logic                clock;
	logic                arst_n;
	logic [COORD_W-1:0]  hcount;
	logic [COORD_W-1:0]  vcount;
	logic                wb_cyc;
	logic                wb_stb;
	logic                wb_we;
	logic [WB_ADR_W-1:0] wb_adr;
	logic [WB_DAT_W-1:0] wb_dat_w;
	logic [WB_DAT_W-1:0] wb_dat_r;
	logic                wb_ack;
	logic [RED_W-1:0]    red;
	logic [GREEN_W-1:0]  green;
	logic [BLUE_W-1:0]   blue;
	logic                data;

	logic [31:0]        lfsr = 32'hfcf7_9aed;
	int                 cycles = 0;
	string              current_test;
	int                 test_errors = 0;
	int                 tests_passed = 0;
	int                 tests_failed = 0;
	logic               model_en;
	int                 model_px;
	int                 model_py;
	logic [PIXEL_W-1:0] model_bmp [depth];
	int                 exp_due [$];
	logic [8:0]         exp_pixel [$];
	int                 exp_h [$];
	int                 exp_v [$];

	sprite_overlay #(
		.sprite_w (sprite_w),
		.sprite_h (sprite_h)
	) uut (.*);

	always #20 clock = ~clock;

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("Run stopped after %0d cycles without finishing the tests", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// Beam position driven on edge k comes out after edge k+2
	always @(negedge clock)
	begin
		if (exp_due.size() > 0 && exp_due[0] == cycles)
		begin
			assert ({data, red, green, blue} === exp_pixel[0])
			else
			begin
				$display("MISMATCH %s pixel (%0d,%0d): expected %h actual %h", current_test,
					exp_h[0], exp_v[0], exp_pixel[0], {data, red, green, blue});
				test_errors++;
			end
			void'(exp_due.pop_front());
			void'(exp_pixel.pop_front());
			void'(exp_h.pop_front());
			void'(exp_v.pop_front());
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [8:0] expected_pixel(input int h, input int v);
		int               col;
		int               row;
		logic [PIXEL_W-1:0] word;
		col = h - model_px;
		row = v - model_py;
		if (!model_en || col < 0 || col >= sprite_w || row < 0 || row >= sprite_h)
			return 9'h000;
		word = model_bmp[row * sprite_w + col];
		if (!word[OPAQUE_BIT])
			return 9'h000;
		return {1'b1, word[7:0]};
	endfunction

	task automatic check_equal(input string what, input logic [31:0] want, input logic [31:0] got);
		assert (want === got)
		else
		begin
			$display("MISMATCH %s %s: expected %0h actual %0h", current_test, what, want, got);
			test_errors++;
		end
	endtask

	task automatic wb_transfer(input logic we, input int adr, input int wdat,
		output logic [WB_DAT_W-1:0] rdat);
		int waits;
		waits = 0;
		rdat = '0;
		@(posedge clock);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= WB_ADR_W'(adr);
		wb_dat_w <= WB_DAT_W'(wdat);
		@(negedge clock); // Request is settled here, ack follows on the next edge
		while (!wb_ack && waits < 4)
		begin
			@(negedge clock);
			waits++;
		end
		assert (wb_ack)
		else
		begin
			$display("%s: no acknowledge within 4 cycles at address %0h", current_test, adr);
			test_errors++;
		end
		if (wb_ack)
		begin
			rdat = wb_dat_r;
			check_equal("ack latency", 1, waits);
		end
		@(posedge clock);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic write_word(input int adr, input int value);
		logic [WB_DAT_W-1:0] unused;
		wb_transfer(1'b1, adr, value, unused);
	endtask

	task automatic read_word(input int adr, output logic [WB_DAT_W-1:0] value);
		wb_transfer(1'b0, adr, 0, value);
	endtask

	task automatic load_pixel(input int idx, input logic [PIXEL_W-1:0] value);
		write_word(BITMAP_BASE + idx, value);
		model_bmp[idx] = value;
	endtask

	task automatic set_position(input int x, input int y);
		write_word(REG_POS_X, x);
		write_word(REG_POS_Y, y);
		model_px = x;
		model_py = y;
	endtask

	task automatic set_enable(input logic en);
		write_word(REG_CTRL, en);
		model_en = en;
	endtask

	// Raster over the window and its margin, wrapping at the screen edges like the beam
	task automatic sweep_window();
		int h;
		int v;
		for (int y = model_py - margin; y < model_py + sprite_h + margin; y++)
			for (int x = model_px - margin; x < model_px + sprite_w + margin; x++)
			begin
				h = (x + screen) % screen;
				v = (y + screen) % screen;
				@(posedge clock);
				hcount <= COORD_W'(h);
				vcount <= COORD_W'(v);
				exp_due.push_back(cycles + 3);
				exp_pixel.push_back(expected_pixel(h, v));
				exp_h.push_back(h);
				exp_v.push_back(v);
			end
		while (exp_due.size() > 0)
			@(posedge clock);
	endtask

	task automatic finish_test();
		if (test_errors == 0)
		begin
			$display("test %s: passed", current_test);
			tests_passed++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", current_test, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	initial
	begin
		logic [WB_DAT_W-1:0] rd;
		int                  val;
		int                  idx;
		clock    = 1'b0;
		arst_n   = 1'b0;
		hcount   = '0;
		vcount   = '0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		model_en = 1'b0;
		model_px = 0;
		model_py = 0;
		idx      = 0;
		repeat (4) @(posedge clock);
		arst_n <= 1'b1;

		current_test = "reset values";
		@(negedge clock);
		check_equal("wb_ack", 0, wb_ack);
		check_equal("data", 0, data);
		check_equal("colour", 0, {red, green, blue});
		read_word(REG_CTRL, rd);
		check_equal("ctrl", 0, rd);
		read_word(REG_POS_X, rd);
		check_equal("pos_x", 0, rd);
		read_word(REG_POS_Y, rd);
		check_equal("pos_y", 0, rd);
		finish_test();

		current_test = "register readback";
		repeat (8)
		begin
			val = random_bits(WB_DAT_W);
			write_word(REG_CTRL, val);
			read_word(REG_CTRL, rd);
			check_equal("ctrl", val & 1, rd);
			val = random_bits(WB_DAT_W);
			write_word(REG_POS_X, val);
			read_word(REG_POS_X, rd);
			check_equal("pos_x", val & (screen - 1), rd);
			val = random_bits(WB_DAT_W);
			write_word(REG_POS_Y, val);
			read_word(REG_POS_Y, rd);
			check_equal("pos_y", val & (screen - 1), rd);
		end
		finish_test();

		current_test = "random bitmap sweep";
		for (int i = 0; i < depth; i++)
			load_pixel(i, PIXEL_W'(random_bits(PIXEL_W)));
		set_position(4 + random_bits(9), 4 + random_bits(8));
		set_enable(1'b1);
		sweep_window();
		finish_test();

		current_test = "transparency and clipping";
		load_pixel(0, 9'h0ff); // Transparent word with a bright colour
		set_position(screen - 10, screen - 3);
		sweep_window();
		finish_test();

		current_test = "enable gating";
		set_position(4 + random_bits(9), 4 + random_bits(8));
		set_enable(1'b0);
		sweep_window();
		set_enable(1'b1);
		sweep_window();
		finish_test();

		current_test = "bitmap rewrite and move";
		repeat (3)
		begin
			idx = random_bits(8) % depth;
			load_pixel(idx, PIXEL_W'(random_bits(PIXEL_W)));
		end
		set_position(random_bits(COORD_W) % (screen - sprite_w),
			random_bits(COORD_W) % (screen - sprite_h));
		sweep_window();
		read_word(BITMAP_BASE + idx, rd);
		check_equal("bitmap read", 0, rd);
		// Past the end of the bitmap, on an address whose low bits select pixel idx
		write_word(BITMAP_BASE + (1 << $clog2(depth)) + idx, model_bmp[idx] ^ 9'h1ff);
		write_word(3, random_bits(WB_DAT_W));
		read_word(3, rd);
		check_equal("unmapped read", 0, rd);
		sweep_window();
		finish_test();

		current_test = "bound assertions";
		check_equal("assertion failures", 0, uut.u_assertions.failures);
		finish_test();

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
